// File: rtl/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// first fetch address after reset
`define FETCH_RESET_PC 32'h8000_0000

// bytes per instruction cache line
`define FETCH_LINE_BYTES 16

// cycles the cache may take to confirm an abort
`define FETCH_ABORT_MAX 64

// offset bits inside one line
`define FETCH_OFFSET_BITS $clog2(`FETCH_LINE_BYTES)

`endif

// File: rtl/fetch_types_pkg.sv
package fetch_types_pkg;

  // byte address on the fetch side
  typedef logic [31:0] fetch_addr_t;

  // line index, address without the byte offset
  typedef logic [27:0] line_addr_t;

  // one cache line, four instruction words
  typedef logic [127:0] line_data_t;

  // one uncompressed instruction
  typedef logic [31:0] inst_word_t;

  // line fetch FSM
  typedef enum logic [1:0] {
    LF_IDLE  = 2'b00, // no request, no held line
    LF_REQ   = 2'b01, // request outstanding
    LF_FULL  = 2'b10, // line held for stage 2
    LF_ABORT = 2'b11  // waiting for the cache to drop a request
  } lf_state_e;

endpackage

// File: rtl/rv_isa_pkg.sv
package rv_isa_pkg;

  // major opcodes that can change the control flow
  typedef enum logic [6:0] {
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // predecode result of one word
  typedef enum logic [2:0] {
    CK_NONE   = 3'd0,
    CK_JAL    = 3'd1, // target from decode
    CK_JALR   = 3'd2, // target from execute
    CK_BRANCH = 3'd3, // no prediction, execute resolves
    CK_SYS    = 3'd4  // ecall or mret
  } ctrl_kind_e;

  // funct12 field of system instructions that redirect
  localparam logic [11:0] SYS_ECALL_IMM = 12'h000;
  localparam logic [11:0] SYS_MRET_IMM  = 12'h302;

endpackage

// File: rtl/line_fetch.sv
`timescale 1ns/1ps

`include "fetch_macros.svh"

module line_fetch import fetch_types_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // from instruction select
  input  logic       line_take_i,
  input  logic       flush_i,
  input  logic       restart_i,
  input  line_addr_t restart_index_i,
  // instruction cache
  output logic        cache_req_o,
  output fetch_addr_t cache_addr_o,
  output logic        cache_abort_o,
  input  logic        cache_ack_i,
  input  line_data_t  cache_data_i,
  input  logic        cache_abort_done_i,
  // to instruction select
  output logic       line_valid_o,
  output line_addr_t line_index_o,
  output line_data_t line_data_o
);

  localparam int OFFSET_BITS = `FETCH_OFFSET_BITS;
  localparam fetch_addr_t RESET_PC = `FETCH_RESET_PC;
  localparam line_addr_t RESET_INDEX = RESET_PC[31:OFFSET_BITS];

  lf_state_e  state;
  line_addr_t req_index;    // line being requested or held
  line_data_t held_data;
  logic       restart_pend; // restart seen while the cache was busy
  line_addr_t pend_index;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= LF_IDLE;
      restart_pend <= 1'b1;        // boot fetch
      pend_index   <= RESET_INDEX;
    end else begin
      case (state)
        LF_IDLE: begin
          if (restart_i) begin
            state     <= LF_REQ;
            req_index <= restart_index_i;
          end else if (restart_pend) begin
            state        <= LF_REQ;
            req_index    <= pend_index;
            restart_pend <= 1'b0;
          end
        end
        LF_REQ: begin
          if (flush_i) begin
            // an ack in the same cycle already ended the request
            state <= cache_ack_i ? LF_IDLE : LF_ABORT;
          end else if (cache_ack_i) begin
            state <= LF_FULL;
          end
        end
        LF_FULL: begin
          if (flush_i) begin
            state <= LF_IDLE;        // drop the held line
          end else if (line_take_i) begin
            state     <= LF_REQ;
            req_index <= req_index + 28'd1; // sequential prefetch
          end
        end
        LF_ABORT: begin
          if (cache_abort_done_i) begin
            if (restart_i) begin
              state     <= LF_REQ;
              req_index <= restart_index_i;
            end else if (restart_pend) begin
              state        <= LF_REQ;
              req_index    <= pend_index;
              restart_pend <= 1'b0;
            end else begin
              state <= LF_IDLE;
            end
          end else if (restart_i) begin
            restart_pend <= 1'b1;    // serve after the abort
            pend_index   <= restart_index_i;
          end
        end
        default: state <= LF_IDLE;
      endcase
    end
  end

  // line payload, loaded on the ack edge
  always_ff @(posedge clk) begin
    if (state == LF_REQ && cache_ack_i) begin
      held_data <= cache_data_i;
    end
  end

  assign cache_req_o   = (state == LF_REQ);
  assign cache_abort_o = (state == LF_ABORT);
  assign cache_addr_o  = {req_index, {OFFSET_BITS{1'b0}}};

  assign line_valid_o = (state == LF_FULL);
  assign line_index_o = req_index;
  assign line_data_o  = held_data;

  a_req_abort_excl: assert property (@(posedge clk) disable iff (rst)
    !(cache_req_o && cache_abort_o));

  // address holds until the ack, or until a flush turns it into an abort
  a_addr_stable: assert property (@(posedge clk) disable iff (rst)
    cache_req_o && !cache_ack_i && !flush_i |=> cache_req_o && $stable(cache_addr_o));

  a_abort_answered: assert property (@(posedge clk) disable iff (rst)
    $rose(cache_abort_o) |-> ##[0:`FETCH_ABORT_MAX] cache_abort_done_i);

endmodule

// File: rtl/inst_select.sv
`timescale 1ns/1ps

`include "fetch_macros.svh"

module inst_select import fetch_types_pkg::*, rv_isa_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  // decode side
  input  logic        dec_ready_i,
  output logic        inst_valid_o,
  output fetch_addr_t pc_o,
  output inst_word_t  inst_o,
  input  logic        jal_done_i,
  input  fetch_addr_t jal_target_i,
  // execute side
  input  logic        exec_done_i,
  input  fetch_addr_t exec_target_i,
  // line fetch stage
  input  logic        line_valid_i,
  input  line_addr_t  line_index_i,
  input  line_data_t  line_data_i,
  output logic        line_take_o,
  output logic        flush_o,
  output logic        restart_o,
  output line_addr_t  restart_index_o
);

  localparam int OFFSET_BITS = `FETCH_OFFSET_BITS;

  fetch_addr_t pc;         // next word to issue
  logic        waiting;    // control transfer issued, no target yet
  logic        cur_valid;
  line_addr_t  cur_index;
  line_data_t  cur_data;

  line_addr_t  pc_line;
  logic        have_line;
  logic        take_ok;
  logic        issue_ok;
  inst_word_t  sel_word;
  ctrl_kind_e  kind;
  fetch_addr_t redir_target;

  assign pc_line   = pc[31:OFFSET_BITS];
  assign have_line = cur_valid && (cur_index == pc_line);
  assign issue_ok  = dec_ready_i && have_line && !waiting;
  assign take_ok   = dec_ready_i && !have_line && !waiting &&
                     line_valid_i && (line_index_i == pc_line);

  // word at pc bits 3:2
  assign sel_word = cur_data[{pc[OFFSET_BITS-1:2], 5'b0} +: 32];

  // predecode
  always_comb begin
    case (sel_word[6:0])
      OP_JAL:    kind = CK_JAL;
      OP_JALR:   kind = CK_JALR;
      OP_BRANCH: kind = CK_BRANCH;
      OP_SYSTEM: begin
        if (sel_word[31:20] == SYS_ECALL_IMM || sel_word[31:20] == SYS_MRET_IMM) begin
          kind = CK_SYS;
        end else begin
          kind = CK_NONE;        // csr ops and the rest fall through
        end
      end
      default:   kind = CK_NONE;
    endcase
  end

  // execute wins over decode
  assign redir_target = exec_done_i ? exec_target_i : jal_target_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc           <= `FETCH_RESET_PC;
      waiting      <= 1'b0;
      cur_valid    <= 1'b0;
      inst_valid_o <= 1'b0;
      line_take_o  <= 1'b0;
      flush_o      <= 1'b0;
      restart_o    <= 1'b0;
    end else begin
      inst_valid_o <= 1'b0;
      line_take_o  <= 1'b0;
      flush_o      <= 1'b0;
      restart_o    <= 1'b0;
      if (waiting) begin
        if (exec_done_i || jal_done_i) begin
          waiting   <= 1'b0;
          pc        <= redir_target;
          restart_o <= 1'b1;
        end
      end else if (issue_ok) begin
        inst_valid_o <= 1'b1;
        pc           <= pc + 32'd4;
        if (kind != CK_NONE) begin
          waiting   <= 1'b1;
          flush_o   <= 1'b1;
          cur_valid <= 1'b0;   // line past the jump is stale
        end
      end else if (take_ok) begin
        line_take_o <= 1'b1;   // bubble cycle
        cur_valid   <= 1'b1;
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (issue_ok) begin
      pc_o   <= pc;
      inst_o <= sel_word;
    end
    if (take_ok) begin
      cur_index <= line_index_i;
      cur_data  <= line_data_i;
    end
    if (waiting) begin
      restart_index_o <= redir_target[31:OFFSET_BITS];
    end
  end

  // no issue can follow a cycle spent waiting for a redirect
  a_no_issue_waiting: assert property (@(posedge clk) disable iff (rst)
    waiting |=> !inst_valid_o);

endmodule

// File: rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_types_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  // instruction cache
  output logic        cache_req_o,
  output fetch_addr_t cache_addr_o,
  output logic        cache_abort_o,
  input  logic        cache_ack_i,
  input  line_data_t  cache_data_i,
  input  logic        cache_abort_done_i,
  // decode
  input  logic        dec_ready_i,
  output logic        inst_valid_o,
  output fetch_addr_t pc_o,
  output inst_word_t  inst_o,
  input  logic        jal_done_i,
  input  fetch_addr_t jal_target_i,
  // execute
  input  logic        exec_done_i,
  input  fetch_addr_t exec_target_i
);

  logic       line_valid;
  line_addr_t line_index;
  line_data_t line_data;
  logic       line_take;
  logic       flush;
  logic       restart;
  line_addr_t restart_index;

  line_fetch u_line_fetch (
    .clk                (clk),
    .rst                (rst),
    .line_take_i        (line_take),
    .flush_i            (flush),
    .restart_i          (restart),
    .restart_index_i    (restart_index),
    .cache_req_o        (cache_req_o),
    .cache_addr_o       (cache_addr_o),
    .cache_abort_o      (cache_abort_o),
    .cache_ack_i        (cache_ack_i),
    .cache_data_i       (cache_data_i),
    .cache_abort_done_i (cache_abort_done_i),
    .line_valid_o       (line_valid),
    .line_index_o       (line_index),
    .line_data_o        (line_data)
  );

  inst_select u_inst_select (
    .clk             (clk),
    .rst             (rst),
    .dec_ready_i     (dec_ready_i),
    .inst_valid_o    (inst_valid_o),
    .pc_o            (pc_o),
    .inst_o          (inst_o),
    .jal_done_i      (jal_done_i),
    .jal_target_i    (jal_target_i),
    .exec_done_i     (exec_done_i),
    .exec_target_i   (exec_target_i),
    .line_valid_i    (line_valid),
    .line_index_i    (line_index),
    .line_data_i     (line_data),
    .line_take_o     (line_take),
    .flush_o         (flush),
    .restart_o       (restart),
    .restart_index_o (restart_index)
  );

endmodule

// File: tb/tb_fetch_top.sv
`timescale 1ns/1ps

`include "fetch_macros.svh"

module tb_fetch_top import fetch_types_pkg::*; ();

  localparam int NUM_WORDS  = 400;
  localparam int IDLE_LIMIT = 1000;   // cycles without an issue
  localparam fetch_addr_t RESET_PC = `FETCH_RESET_PC;

  logic        clk = 1'b0;
  logic        rst;
  logic        cache_req_o;
  fetch_addr_t cache_addr_o;
  logic        cache_abort_o;
  logic        cache_ack_i;
  line_data_t  cache_data_i;
  logic        cache_abort_done_i;
  logic        dec_ready_i;
  logic        inst_valid_o;
  fetch_addr_t pc_o;
  inst_word_t  inst_o;
  logic        jal_done_i;
  fetch_addr_t jal_target_i;
  logic        exec_done_i;
  fetch_addr_t exec_target_i;

  int          value_errs = 0;
  int          proto_errs = 0;
  int          run_errs   = 0;
  int          issued     = 0;
  fetch_addr_t exp_pc     = RESET_PC;

  logic [31:0] rng        = 32'h6f89;
  int          ready_left = 0;
  int          req_left   = -1;       // -1 means no request being served
  int          abort_left = -1;
  int          redir_left = -1;
  logic        redir_jal  = 1'b0;
  fetch_addr_t redir_pc   = '0;
  logic        abort_open = 1'b0;     // abort seen, done not yet given
  logic        abort_due  = 1'b0;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int rand_below(input int n);
    rng = xorshift(rng);
    return int'(rng % n);
  endfunction

  function automatic logic [31:0] mix32(input logic [31:0] a);
    logic [31:0] h;
    h = a * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    h = h * 32'h85eb_ca6b;
    h = h ^ (h >> 13);
    return h;
  endfunction

  // program image, about one word in eight transfers control
  function automatic inst_word_t mem_word(input fetch_addr_t addr);
    logic [31:0] h;
    h = mix32(addr);
    if (h[2:0] == 3'd0) begin
      case (h[5:3])
        3'd0, 3'd1: return {h[31:7], 7'b1101111};                   // jal
        3'd2, 3'd3: return {h[31:15], 3'b000, h[11:7], 7'b1100111}; // jalr
        3'd4, 3'd5: return {h[31:7], 7'b1100011};                   // branch
        3'd6:       return 32'h0000_0073;                            // ecall
        default:    return 32'h3020_0073;                            // mret
      endcase
    end else if (h[2:0] == 3'd1) begin
      return {h[31:21], 1'b1, h[19:7], 7'b1110011}; // odd funct12, plain system op
    end
    return {h[31:7], 7'b0010011};
  endfunction

  function automatic line_data_t line_of(input fetch_addr_t addr);
    fetch_addr_t base;
    base = {addr[31:4], 4'b0000};
    return {mem_word(base + 32'd12), mem_word(base + 32'd8),
            mem_word(base + 32'd4), mem_word(base)};
  endfunction

  // 0 sequential, 1 target from decode, 2 target from execute
  function automatic int transfer_kind(input inst_word_t w);
    case (w[6:0])
      7'b1101111:             return 1;
      7'b1100111, 7'b1100011: return 2;
      7'b1110011:             return (w[31:20] == 12'h000 || w[31:20] == 12'h302) ? 2 : 0;
      default:                return 0;
    endcase
  endfunction

  function automatic fetch_addr_t redirect_target(input fetch_addr_t pc);
    logic [31:0] h;
    h = mix32(pc ^ 32'h5bd1_e995);
    return RESET_PC + {20'd0, h[11:2], 2'b00}; // 4 KB window
  endfunction

  function automatic fetch_addr_t next_pc(input fetch_addr_t pc, input inst_word_t w);
    if (transfer_kind(w) != 0) begin
      return redirect_target(pc);
    end
    return pc + 32'd4;
  endfunction

  initial begin
    forever #50 clk = ~clk;
  end

  fetch_top i_fetch_top (.*);

  // comparator
  always @(negedge clk) begin
    if (inst_valid_o) begin
      assert (pc_o == exp_pc) else begin
        $display("FAIL pc_o: got %h, expected %h", pc_o, exp_pc);
        value_errs++;
      end
      assert (inst_o == mem_word(exp_pc)) else begin
        $display("FAIL inst_o at %h: got %h, expected %h", exp_pc, inst_o, mem_word(exp_pc));
        value_errs++;
      end
      exp_pc = next_pc(exp_pc, mem_word(exp_pc));
      issued++;
    end
  end

  // cache, decode and execute models
  initial begin
    cache_ack_i        = 1'b0;
    cache_data_i       = '0;
    cache_abort_done_i = 1'b0;
    dec_ready_i        = 1'b0;
    jal_done_i         = 1'b0;
    jal_target_i       = '0;
    exec_done_i        = 1'b0;
    exec_target_i      = '0;
    forever begin
      @(negedge clk);
      cache_ack_i        = 1'b0;
      cache_abort_done_i = 1'b0;
      jal_done_i         = 1'b0;
      exec_done_i        = 1'b0;
      if (abort_due) begin
        assert (cache_abort_o) else begin
          $display("abort not raised for a request outstanding at a control transfer");
          proto_errs++;
        end
        abort_due = 1'b0;
      end
      if (inst_valid_o) begin
        // dec_ready_i still holds the level seen at the issuing edge
        assert (dec_ready_i) else begin
          $display("word issued while decode was not ready");
          proto_errs++;
        end
      end
      if (ready_left == 0) begin
        dec_ready_i = (rand_below(4) != 0);         // low about a quarter of the time
        ready_left  = 1 + rand_below(dec_ready_i ? 12 : 8);
      end
      ready_left--;
      if (inst_valid_o) begin
        assert (redir_left < 0) else begin
          $display("word issued while a redirect was still outstanding");
          proto_errs++;
        end
        if (transfer_kind(inst_o) != 0) begin
          redir_jal  = (transfer_kind(inst_o) == 1);
          redir_pc   = pc_o;
          redir_left = rand_below(8);
          abort_due  = cache_req_o;                 // flush lands on this request
        end
      end
      if (redir_left == 0) begin
        jal_done_i    = redir_jal;
        exec_done_i   = !redir_jal;
        // the target without a pulse points elsewhere
        jal_target_i  = redirect_target(redir_pc) ^ (redir_jal ? 32'h0 : 32'h800);
        exec_target_i = redirect_target(redir_pc) ^ (redir_jal ? 32'h800 : 32'h0);
      end
      if (redir_left >= 0) begin
        redir_left--;
      end
      if (cache_abort_o) begin
        req_left   = -1;                            // request dropped by the abort
        abort_open = 1'b1;
        if (abort_left < 0) begin
          abort_left = rand_below(8);
        end
        if (abort_left == 0) begin
          cache_abort_done_i = 1'b1;
          abort_open         = 1'b0;
        end
        abort_left--;
      end else if (cache_req_o) begin
        assert (!abort_open) else begin
          $display("new cache request before the abort was answered");
          proto_errs++;
        end
        if (req_left < 0) begin
          req_left = rand_below(6);                 // 1 to 6 cycles to the ack
        end
        if (req_left == 0) begin
          cache_ack_i  = 1'b1;
          cache_data_i = line_of(cache_addr_o);
          abort_due    = 1'b0;                      // ack and flush meet, no abort
        end
        req_left--;
      end else begin
        req_left = -1;
      end
    end
  end

  initial begin
    int cyc;
    int last;
    int idle;
    rst = 1'b1;
    repeat (5) @(negedge clk);
    assert (!inst_valid_o && !cache_req_o && !cache_abort_o) else begin
      $display("fetch outputs not idle during reset");
      run_errs++;
    end
    rst = 1'b0;
    cyc = 0;
    while (!cache_req_o && cyc < 20) begin
      @(negedge clk);
      cyc++;
    end
    if (!cache_req_o) begin
      $display("timeout: no cache request after reset");
      run_errs++;
    end else begin
      assert (cache_addr_o == RESET_PC) else begin
        $display("FAIL cache_addr_o: got %h, expected %h", cache_addr_o, RESET_PC);
        value_errs++;
      end
    end
    idle = 0;
    last = issued;
    while (issued < NUM_WORDS && idle < IDLE_LIMIT) begin
      @(posedge clk);
      if (issued != last) begin
        last = issued;
        idle = 0;
      end else begin
        idle++;
      end
    end
    if (issued < NUM_WORDS) begin
      $display("timeout: no word issued for %0d cycles, expected pc %h", IDLE_LIMIT, exp_pc);
      run_errs++;
    end
    $display("issued %0d words, value errors %0d, protocol errors %0d, run errors %0d",
             issued, value_errs, proto_errs, run_errs);
    if (value_errs + proto_errs + run_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+rtl
rtl/fetch_types_pkg.sv
rtl/rv_isa_pkg.sv
rtl/line_fetch.sv
rtl/inst_select.sv
rtl/fetch_top.sv
tb/tb_fetch_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f flist.f --top-module tb_fetch_top
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_fetch_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^TESTBENCH PASSED$"; then
  exit 0
fi
exit 1
